/* verilog/irq_pkg.sv */
`default_nettype none

package irq_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sizes.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_SOURCES    = 4;
    localparam int SOURCE_BITS    = 2;
    // One scancode-sized byte per event.
    localparam int VALUE_BITS     = 8;
    localparam int ADDR_BITS      = 32;
    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = 2;

    // ~~~~~~~~~~~~~~~~~~~~
    // Vector types.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [SOURCE_BITS-1:0] source_id_t;
    typedef logic [VALUE_BITS-1:0]  event_value_t;
    typedef logic [ADDR_BITS-1:0]   code_addr_t;

    // Hardware event as it arrives from a source.
    typedef struct packed {
        source_id_t   source;
        event_value_t value;
    } irq_event_t;

    // One write into the vector table.
    typedef struct packed {
        logic       en;
        source_id_t source;
        code_addr_t offset;
    } vector_write_t;

    // Dispatch handed to the CPU side.
    typedef struct packed {
        code_addr_t   isr_addr;
        source_id_t   source;
        event_value_t value;
    } dispatch_t;

    typedef enum logic [0:0] {ROUTE_IDLE, ROUTE_ACK} router_state_t;

    typedef enum logic [1:0] {DISP_IDLE, DISP_REQ, DISP_RELEASE, DISP_SERVICE} dispatch_state_t;

endpackage

`default_nettype wire

/* verilog/event_router.sv */
`timescale 1ns/1ps
`default_nettype none

module event_router(
    input  logic                            CLOCK_50,
    input  logic                            rst_n_i,
    input  logic                            event_req_i,
    input  irq_pkg::irq_event_t             event_i,
    input  logic [irq_pkg::NUM_SOURCES-1:0] full_i,
    output logic                            event_ack_o,
    output logic [irq_pkg::NUM_SOURCES-1:0] push_o,
    output irq_pkg::event_value_t           push_value_o
);

irq_pkg::router_state_t state_q;

// Queue selected by the incoming event's source.
logic target_full;

// Event is taken this cycle.
logic accept;

assign target_full = full_i[event_i.source];
assign accept = (state_q == irq_pkg::ROUTE_IDLE) && event_req_i && !target_full;

// ~~~~~~~~~~~~~~~~~~~~
// Queue write side.
// ~~~~~~~~~~~~~~~~~~~~

// One-hot push towards the queue of the event's source.
always_comb
begin
    push_o = '0;
    if (accept)
        push_o[event_i.source] = 1'b1;
end

// All queues share the value bus and only the push bit selects.
assign push_value_o = event_i.value;

// ~~~~~~~~~~~~~~~~~~~~
// Input handshake.
// ~~~~~~~~~~~~~~~~~~~~

// Ack follows the write by one edge and stays up until req is seen low.
always_ff @(posedge CLOCK_50)
begin
    if (!rst_n_i)
    begin
        state_q <= irq_pkg::ROUTE_IDLE;
    end
    else
    begin
        case (state_q)
            irq_pkg::ROUTE_IDLE:
            begin
                // A full queue simply holds the source off.
                if (accept)
                    state_q <= irq_pkg::ROUTE_ACK;
            end
            irq_pkg::ROUTE_ACK:
            begin
                if (!event_req_i)
                    state_q <= irq_pkg::ROUTE_IDLE;
            end
            default:
            begin
                state_q <= irq_pkg::ROUTE_IDLE;
            end
        endcase
    end
end

assign event_ack_o = (state_q == irq_pkg::ROUTE_ACK);

endmodule

`default_nettype wire

/* verilog/source_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module source_queue(
    input  logic                  CLOCK_50,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  irq_pkg::event_value_t value_i,
    input  logic                  pop_i,
    output irq_pkg::event_value_t head_o,
    output logic                  empty_o,
    output logic                  full_o
);

// Storage for the queued event values.
irq_pkg::event_value_t mem [irq_pkg::QUEUE_DEPTH];

logic [irq_pkg::QUEUE_PTR_BITS-1:0] rd_ptr_q;
logic [irq_pkg::QUEUE_PTR_BITS-1:0] wr_ptr_q;
// One bit wider than the pointers so that a full queue is distinct from empty.
logic [irq_pkg::QUEUE_PTR_BITS:0]   count_q;

logic do_push;
logic do_pop;

assign do_push = push_i && !full_o;
assign do_pop  = pop_i && !empty_o;

always_ff @(posedge CLOCK_50)
begin
    if (do_push)
        mem[wr_ptr_q] <= value_i;
end

// Pointers wrap naturally at QUEUE_DEPTH.
always_ff @(posedge CLOCK_50)
begin
    if (!rst_n_i)
    begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        count_q  <= '0;
    end
    else
    begin
        if (do_push)
            wr_ptr_q <= wr_ptr_q + irq_pkg::QUEUE_PTR_BITS'(1);
        if (do_pop)
            rd_ptr_q <= rd_ptr_q + irq_pkg::QUEUE_PTR_BITS'(1);
        if (do_push && !do_pop)
            count_q <= count_q + (irq_pkg::QUEUE_PTR_BITS + 1)'(1);
        else if (do_pop && !do_push)
            count_q <= count_q - (irq_pkg::QUEUE_PTR_BITS + 1)'(1);
    end
end

// Oldest entry is always on the output with no read delay.
assign head_o  = mem[rd_ptr_q];
assign empty_o = (count_q == '0);
assign full_o  = (count_q == (irq_pkg::QUEUE_PTR_BITS + 1)'(irq_pkg::QUEUE_DEPTH));

endmodule

`default_nettype wire

/* verilog/dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit(
    input  logic                            CLOCK_50,
    input  logic                            rst_n_i,
    input  logic [irq_pkg::NUM_SOURCES-1:0] empty_i,
    input  irq_pkg::event_value_t           head_i [irq_pkg::NUM_SOURCES],
    input  irq_pkg::vector_write_t          vector_write_i,
    input  irq_pkg::code_addr_t             code_base_i,
    input  logic                            dispatch_ack_i,
    input  logic                            eoi_i,
    output logic [irq_pkg::NUM_SOURCES-1:0] pop_o,
    output logic                            dispatch_req_o,
    output irq_pkg::dispatch_t              dispatch_o,
    output logic                            in_service_o
);

irq_pkg::dispatch_state_t state_q;

// Vector table, one ISR offset per source.
irq_pkg::code_addr_t vector_table_q [irq_pkg::NUM_SOURCES];

irq_pkg::source_id_t sel_src;
irq_pkg::code_addr_t sel_isr_addr;
logic                any_ready;
logic                start;

// ~~~~~~~~~~~~~~~~~~~~
// Vector table.
// ~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge CLOCK_50)
begin
    if (!rst_n_i)
    begin
        for (int i = 0; i < irq_pkg::NUM_SOURCES; i++)
            vector_table_q[i] <= '0;
    end
    else if (vector_write_i.en)
    begin
        vector_table_q[vector_write_i.source] <= vector_write_i.offset;
    end
end

// ~~~~~~~~~~~~~~~~~~~~
// Source selection.
// ~~~~~~~~~~~~~~~~~~~~

// Fixed priority, lowest source number wins.
always_comb
begin
    sel_src = '0;
    for (int i = irq_pkg::NUM_SOURCES - 1; i >= 0; i--)
    begin
        if (!empty_i[i])
            sel_src = irq_pkg::source_id_t'(i);
    end
end

assign any_ready = (empty_i != '1);
assign start = (state_q == irq_pkg::DISP_IDLE) && any_ready;

// ISR entry point is relative to the code section.
assign sel_isr_addr = code_base_i + vector_table_q[sel_src];

always_comb
begin
    pop_o = '0;
    if (start)
        pop_o[sel_src] = 1'b1;
end

// ~~~~~~~~~~~~~~~~~~~~
// Dispatch handshake.
// ~~~~~~~~~~~~~~~~~~~~

// Dispatch payload is captured with the pop and held through the handshake.
always_ff @(posedge CLOCK_50)
begin
    if (start)
    begin
        dispatch_o.isr_addr <= sel_isr_addr;
        dispatch_o.source   <= sel_src;
        dispatch_o.value    <= head_i[sel_src];
    end
end

always_ff @(posedge CLOCK_50)
begin
    if (!rst_n_i)
    begin
        state_q <= irq_pkg::DISP_IDLE;
    end
    else
    begin
        case (state_q)
            irq_pkg::DISP_IDLE:
            begin
                if (start)
                    state_q <= irq_pkg::DISP_REQ;
            end
            irq_pkg::DISP_REQ:
            begin
                // CPU side has taken the dispatch.
                if (dispatch_ack_i)
                    state_q <= irq_pkg::DISP_RELEASE;
            end
            irq_pkg::DISP_RELEASE:
            begin
                if (!dispatch_ack_i)
                    state_q <= irq_pkg::DISP_SERVICE;
            end
            irq_pkg::DISP_SERVICE:
            begin
                // Nothing new goes out while the ISR runs.
                if (eoi_i)
                    state_q <= irq_pkg::DISP_IDLE;
            end
            default:
            begin
                state_q <= irq_pkg::DISP_IDLE;
            end
        endcase
    end
end

assign dispatch_req_o = (state_q == irq_pkg::DISP_REQ);
assign in_service_o   = (state_q == irq_pkg::DISP_SERVICE);

endmodule

`default_nettype wire

/* verilog/interrupt_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller(
    input  logic                   CLOCK_50,
    input  logic                   rst_n_i,
    input  logic                   event_req_i,
    input  irq_pkg::irq_event_t    event_i,
    output logic                   event_ack_o,
    input  irq_pkg::vector_write_t vector_write_i,
    input  irq_pkg::code_addr_t    code_base_i,
    output logic                   dispatch_req_o,
    output irq_pkg::dispatch_t     dispatch_o,
    input  logic                   dispatch_ack_i,
    input  logic                   eoi_i,
    output logic                   in_service_o
);

wire logic [irq_pkg::NUM_SOURCES-1:0] push;
wire logic [irq_pkg::NUM_SOURCES-1:0] full;
wire logic [irq_pkg::NUM_SOURCES-1:0] empty;
wire logic [irq_pkg::NUM_SOURCES-1:0] pop;
wire irq_pkg::event_value_t           push_value;
wire irq_pkg::event_value_t           head [irq_pkg::NUM_SOURCES];

event_router router(
    .CLOCK_50     (CLOCK_50),
    .rst_n_i      (rst_n_i),
    .event_req_i  (event_req_i),
    .event_i      (event_i),
    .full_i       (full),
    .event_ack_o  (event_ack_o),
    .push_o       (push),
    .push_value_o (push_value)
);

// One queue per source.
for (genvar g = 0; g < irq_pkg::NUM_SOURCES; g++)
begin : gen_queue
    source_queue queue(
        .CLOCK_50 (CLOCK_50),
        .rst_n_i  (rst_n_i),
        .push_i   (push[g]),
        .value_i  (push_value),
        .pop_i    (pop[g]),
        .head_o   (head[g]),
        .empty_o  (empty[g]),
        .full_o   (full[g])
    );
end

dispatch_unit dispatcher(
    .CLOCK_50       (CLOCK_50),
    .rst_n_i        (rst_n_i),
    .empty_i        (empty),
    .head_i         (head),
    .vector_write_i (vector_write_i),
    .code_base_i    (code_base_i),
    .dispatch_ack_i (dispatch_ack_i),
    .eoi_i          (eoi_i),
    .pop_o          (pop),
    .dispatch_req_o (dispatch_req_o),
    .dispatch_o     (dispatch_o),
    .in_service_o   (in_service_o)
);

endmodule

`default_nettype wire

/* tests/interrupt_controller_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller_asserts(
    input logic               CLOCK_50,
    input logic               rst_n_i,
    input logic               event_req_i,
    input logic               event_ack_o,
    input logic               dispatch_req_o,
    input irq_pkg::dispatch_t dispatch_o,
    input logic               dispatch_ack_i,
    input logic               in_service_o
);

// ~~~~~~~~~~~~~~~~~~~~
// Dispatch output.
// ~~~~~~~~~~~~~~~~~~~~

// Request and payload hold until the CPU side acks.
req_held: assert property (@(posedge CLOCK_50) disable iff (!rst_n_i)
    dispatch_req_o && !dispatch_ack_i |=> dispatch_req_o && $stable(dispatch_o))
    else $error("dispatch_req_o or dispatch_o changed before dispatch_ack_i");

// No new dispatch while an ISR is still running.
no_req_in_service: assert property (@(posedge CLOCK_50) disable iff (!rst_n_i)
    $rose(dispatch_req_o) |-> !in_service_o && !$past(in_service_o))
    else $error("dispatch_req_o rose while in_service_o was high");

// ~~~~~~~~~~~~~~~~~~~~
// Event input.
// ~~~~~~~~~~~~~~~~~~~~

// Ack goes up on the edge that saw req high.
ack_needs_req: assert property (@(posedge CLOCK_50) disable iff (!rst_n_i)
    $rose(event_ack_o) |-> $past(event_req_i))
    else $error("event_ack_o rose without event_req_i");

endmodule

bind interrupt_controller interrupt_controller_asserts asserts(
    .CLOCK_50       (CLOCK_50),
    .rst_n_i        (rst_n_i),
    .event_req_i    (event_req_i),
    .event_ack_o    (event_ack_o),
    .dispatch_req_o (dispatch_req_o),
    .dispatch_o     (dispatch_o),
    .dispatch_ack_i (dispatch_ack_i),
    .in_service_o   (in_service_o)
);

`default_nettype wire

/* tests/tb_interrupt_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_interrupt_controller;

localparam int NUM_EVENTS   = 8;
localparam int RESET_CYCLES = 10;
localparam int WAIT_LIMIT   = 50;
localparam int ACK_LIMIT    = 2;
localparam irq_pkg::code_addr_t CODE_BASE = 32'h0004_0000;

// Selectors for the handshake outputs watched by wait_level.
localparam int SIG_EVENT_ACK    = 0;
localparam int SIG_DISPATCH_REQ = 1;
localparam int SIG_IN_SERVICE   = 2;

logic                   CLOCK_50 = 1'b0;
logic                   rst_n_i;
logic                   event_req_i;
irq_pkg::irq_event_t    event_i;
logic                   event_ack_o;
irq_pkg::vector_write_t vector_write_i;
irq_pkg::code_addr_t    code_base_i;
logic                   dispatch_req_o;
irq_pkg::dispatch_t     dispatch_o;
logic                   dispatch_ack_i;
logic                   eoi_i;
logic                   in_service_o;

irq_pkg::irq_event_t ev_table [NUM_EVENTS];
irq_pkg::code_addr_t vec_offset [irq_pkg::NUM_SOURCES];
integer              seed;

// Reference model with one queue per source and the dispatch held by the DUT.
irq_pkg::event_value_t model_q [irq_pkg::NUM_SOURCES][$];
irq_pkg::dispatch_t    model_slot;
logic                  model_busy;

int errors;
int checks;
int test_start_errors;

interrupt_controller uut(
    .CLOCK_50       (CLOCK_50),
    .rst_n_i        (rst_n_i),
    .event_req_i    (event_req_i),
    .event_i        (event_i),
    .event_ack_o    (event_ack_o),
    .vector_write_i (vector_write_i),
    .code_base_i    (code_base_i),
    .dispatch_req_o (dispatch_req_o),
    .dispatch_o     (dispatch_o),
    .dispatch_ack_i (dispatch_ack_i),
    .eoi_i          (eoi_i),
    .in_service_o   (in_service_o)
);

always #50 CLOCK_50 = ~CLOCK_50;

// ~~~~~~~~~~~~~~~~~~~~
// Model.
// ~~~~~~~~~~~~~~~~~~~~

// An idle dispatcher takes the oldest event of the lowest busy source.
function automatic void model_capture();
    for (int s = 0; s < irq_pkg::NUM_SOURCES; s++)
    begin
        if (!model_busy && model_q[s].size() > 0)
        begin
            model_slot.isr_addr = CODE_BASE + vec_offset[s];
            model_slot.source   = irq_pkg::source_id_t'(s);
            model_slot.value    = model_q[s].pop_front();
            model_busy          = 1'b1;
        end
    end
endfunction

function automatic void model_push(input irq_pkg::irq_event_t ev);
    model_q[ev.source].push_back(ev.value);
    model_capture();
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// Checks and handshakes.
// ~~~~~~~~~~~~~~~~~~~~

task automatic compare(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
        $display("mismatch %s: expected %h, got %h", name, expected, actual);
        errors++;
    end
endtask

function automatic logic probe(input int which);
    case (which)
        SIG_EVENT_ACK:    return event_ack_o;
        SIG_DISPATCH_REQ: return dispatch_req_o;
        default:          return in_service_o;
    endcase
endfunction

// Waits on falling edges until the output reaches the level.
task automatic wait_level(input int which, input logic level, input string what,
                          output int cycles);
    cycles = 0;
    while (probe(which) !== level && cycles < WAIT_LIMIT)
    begin
        @(negedge CLOCK_50);
        cycles++;
    end
    if (probe(which) !== level)
    begin
        $display("timeout: %s did not go to %0d within %0d cycles", what, level, WAIT_LIMIT);
        errors++;
    end
endtask

task automatic raise_event(input irq_pkg::irq_event_t ev);
    event_i     = ev;
    event_req_i = 1'b1;
endtask

task automatic finish_event(input irq_pkg::irq_event_t ev);
    int cycles;
    event_req_i = 1'b0;
    wait_level(SIG_EVENT_ACK, 1'b0, "event_ack_o", cycles);
    model_push(ev);
endtask

task automatic send_event(input irq_pkg::irq_event_t ev, output int cycles);
    raise_event(ev);
    wait_level(SIG_EVENT_ACK, 1'b1, "event_ack_o", cycles);
    finish_event(ev);
endtask

// Checks the dispatch and runs the CPU side of the handshake.
task automatic take_dispatch();
    int cycles;
    wait_level(SIG_DISPATCH_REQ, 1'b1, "dispatch_req_o", cycles);
    if (!model_busy)
    begin
        $display("dispatch request seen with no event left to dispatch");
        errors++;
    end
    compare("dispatch_o.isr_addr", model_slot.isr_addr, dispatch_o.isr_addr);
    compare("dispatch_o.source", 32'(model_slot.source), 32'(dispatch_o.source));
    compare("dispatch_o.value", 32'(model_slot.value), 32'(dispatch_o.value));
    dispatch_ack_i = 1'b1;
    wait_level(SIG_DISPATCH_REQ, 1'b0, "dispatch_req_o", cycles);
    dispatch_ack_i = 1'b0;
    wait_level(SIG_IN_SERVICE, 1'b1, "in_service_o", cycles);
endtask

task automatic end_interrupt();
    eoi_i = 1'b1;
    @(negedge CLOCK_50);
    eoi_i      = 1'b0;
    model_busy = 1'b0;
    model_capture();
endtask

task automatic end_test(input int num, input string name);
    if (errors == test_start_errors)
        $display("test %0d %s: ok", num, name);
    else
        $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
    test_start_errors = errors;
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Stimulus.
// ~~~~~~~~~~~~~~~~~~~~
initial
begin
    int cycles;
    int blocked_acks;
    irq_pkg::irq_event_t ev;
    rst_n_i           = 1'b0;
    event_req_i       = 1'b0;
    event_i           = '0;
    vector_write_i    = '0;
    code_base_i       = CODE_BASE;
    dispatch_ack_i    = 1'b0;
    eoi_i             = 1'b0;
    errors            = 0;
    checks            = 0;
    test_start_errors = 0;
    model_busy        = 1'b0;
    seed              = 32'h8b6d4d7e;
    vec_offset = '{32'h0000_0100, 32'h0000_0240, 32'h0000_03c0, 32'h0000_0480};
    // Zero values in the lower rows are replaced by random ones.
    ev_table = '{
        '{2'd3, 8'h1c}, '{2'd1, 8'h32}, '{2'd2, 8'h23}, '{2'd1, 8'h2b},
        '{2'd0, 8'h00}, '{2'd3, 8'h00}, '{2'd0, 8'h00}, '{2'd2, 8'h00}
    };
    for (int i = NUM_EVENTS / 2; i < NUM_EVENTS; i++)
        ev_table[i].value = irq_pkg::event_value_t'($random(seed));

    repeat (RESET_CYCLES) @(negedge CLOCK_50);
    rst_n_i = 1'b1;
    @(negedge CLOCK_50);
    compare("event_ack_o", 32'h0, 32'(event_ack_o));
    compare("dispatch_req_o", 32'h0, 32'(dispatch_req_o));
    compare("in_service_o", 32'h0, 32'(in_service_o));
    end_test(1, "reset state");

    for (int s = 0; s < irq_pkg::NUM_SOURCES; s++)
    begin
        vector_write_i = '{en: 1'b1, source: irq_pkg::source_id_t'(s), offset: vec_offset[s]};
        @(negedge CLOCK_50);
    end
    vector_write_i = '0;
    ev = '{source: 2'd2, value: 8'ha5};
    send_event(ev, cycles);
    take_dispatch();
    end_interrupt();
    end_test(2, "single dispatch");

    // All events go in while the first dispatch is held unacked.
    for (int i = 0; i < NUM_EVENTS; i++)
    begin
        send_event(ev_table[i], cycles);
        checks++;
        if (cycles > ACK_LIMIT)
        begin
            $display("event %0d acked after %0d cycles, limit is %0d", i, cycles, ACK_LIMIT);
            errors++;
        end
    end
    for (int i = 0; i < NUM_EVENTS; i++)
    begin
        take_dispatch();
        // The last one stays in service for the next test.
        if (i < NUM_EVENTS - 1)
            end_interrupt();
    end
    end_test(3, "priority order");

    for (int i = 0; i < irq_pkg::QUEUE_DEPTH; i++)
    begin
        ev = '{source: 2'd1, value: 8'h40 + irq_pkg::event_value_t'(i)};
        send_event(ev, cycles);
    end
    ev = '{source: 2'd1, value: 8'h4f};
    raise_event(ev);
    blocked_acks = 0;
    repeat (20)
    begin
        @(negedge CLOCK_50);
        if (event_ack_o)
            blocked_acks++;
    end
    checks++;
    if (blocked_acks != 0)
    begin
        $display("event to a full queue was acked");
        errors++;
    end
    end_interrupt();
    wait_level(SIG_EVENT_ACK, 1'b1, "event_ack_o", cycles);
    finish_event(ev);
    end_test(4, "full queue back-pressure");

    take_dispatch();
    repeat (10)
    begin
        @(negedge CLOCK_50);
        checks++;
        if (dispatch_req_o || !in_service_o)
        begin
            $display("dispatch state changed while in service without eoi_i");
            errors++;
        end
    end
    end_interrupt();
    while (model_busy)
    begin
        take_dispatch();
        end_interrupt();
    end
    compare("dispatch_req_o", 32'h0, 32'(dispatch_req_o));
    compare("in_service_o", 32'h0, 32'(in_service_o));
    end_test(5, "in-service blocking");

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
        $display("All checks passed");
    else
        $display("Checks failed");
    $finish;
end

// Watchdog sized from the event table.
initial
begin
    repeat (RESET_CYCLES + NUM_EVENTS * 200) @(posedge CLOCK_50);
    $display("watchdog expired, the run did not finish in time");
    $display("Checks failed");
    $finish;
end

endmodule

`default_nettype wire

/* files.f */
verilog/irq_pkg.sv
verilog/event_router.sv
verilog/source_queue.sv
verilog/dispatch_unit.sv
verilog/interrupt_controller.sv
tests/interrupt_controller_asserts.sv
tests/tb_interrupt_controller.sv

/* Makefile */
# Verilator build and run for the interrupt controller testbench.

VERILATOR ?= verilator
TOP       ?= tb_interrupt_controller
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is taken from the simulation output.
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All checks passed"

clean:
	rm -rf $(BUILD_DIR)
